/* verilog/pad_map_pkg.sv */
// Fixed ten-pad frame, pad indices must follow the pin order of the pad ring
`default_nettype none

package pad_map_pkg;

   ////////////////////////////////////////////////////////////
   // Pad frame size
   ////////////////////////////////////////////////////////////

   // Also the width of the GPIO bank
   localparam int unsigned N_PADS = 10;

   ////////////////////////////////////////////////////////////
   // Pad indices
   ////////////////////////////////////////////////////////////

   // Quad-SPI master data lines
   localparam int unsigned PAD_SDIO0    = 0;
   localparam int unsigned PAD_SDIO1    = 1;
   localparam int unsigned PAD_SDIO2    = 2;
   localparam int unsigned PAD_SDIO3    = 3;
   // SPI control
   localparam int unsigned PAD_CSN0     = 4;
   localparam int unsigned PAD_SCK      = 5;
   // UART
   localparam int unsigned PAD_UART_RX  = 6;
   localparam int unsigned PAD_UART_TX  = 7;
   // I2C0
   localparam int unsigned PAD_I2C0_SDA = 8;
   localparam int unsigned PAD_I2C0_SCL = 9;

   ////////////////////////////////////////////////////////////
   // Pad function select and configuration
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      PAD_MODE_PERIPH = 2'd0,
      PAD_MODE_GPIO   = 2'd1,
      PAD_MODE_ALT    = 2'd2,
      PAD_MODE_NONE   = 2'd3
   } pad_mode_t;

   // Drive strength and pull bits, opaque to the mux
   localparam int unsigned PAD_CFG_W = 6;
   typedef logic [PAD_CFG_W-1:0] pad_cfg_t;

endpackage

`default_nettype wire

/* verilog/periph_pkg.sv */
// Single quad-SPI master with one chip select, one UART and exactly two I2C controllers
`default_nettype none

package periph_pkg;

   ////////////////////////////////////////////////////////////
   // Peripheral widths
   ////////////////////////////////////////////////////////////

   // Data lines of the quad-SPI master
   localparam int unsigned SPI_LINES = 4;

   // I2C controllers on the bus vectors
   localparam int unsigned N_I2C = 2;

   // Bit positions of the two I2C controllers
   localparam int unsigned I2C0 = 0;
   localparam int unsigned I2C1 = 1;

endpackage

`default_nettype wire

/* verilog/pad_route_table.sv */
// Pure combinational, places peripheral outputs on pad slots for peripheral and alternate modes
`timescale 1ns/1ps
`default_nettype none

module pad_route_table
   import pad_map_pkg::*;
   import periph_pkg::*;
(
   input  logic                 spi_clk_i,
   input  logic                 spi_csn_i,
   input  logic [SPI_LINES-1:0] spi_oen_i,
   input  logic [SPI_LINES-1:0] spi_sdo_i,
   input  logic                 uart_tx_i,
   input  logic [N_I2C-1:0]     i2c_sda_out_i,
   input  logic [N_I2C-1:0]     i2c_sda_oe_i,
   input  logic [N_I2C-1:0]     i2c_scl_out_i,
   input  logic [N_I2C-1:0]     i2c_scl_oe_i,
   output logic [N_PADS-1:0]    periph_out_o,
   output logic [N_PADS-1:0]    periph_oe_o,
   output logic [N_PADS-1:0]    alt_out_o,
   output logic [N_PADS-1:0]    alt_oe_o
);

   ////////////////////////////////////////////////////////////
   // Peripheral mode
   ////////////////////////////////////////////////////////////

   always_comb begin
      periph_out_o = '0;
      periph_oe_o  = '0;

      // SPI master drives enable low
      periph_out_o[PAD_SDIO0] = spi_sdo_i[0];
      periph_oe_o[PAD_SDIO0]  = ~spi_oen_i[0];
      periph_out_o[PAD_SDIO1] = spi_sdo_i[1];
      periph_oe_o[PAD_SDIO1]  = ~spi_oen_i[1];
      periph_out_o[PAD_SDIO2] = spi_sdo_i[2];
      periph_oe_o[PAD_SDIO2]  = ~spi_oen_i[2];
      periph_out_o[PAD_SDIO3] = spi_sdo_i[3];
      periph_oe_o[PAD_SDIO3]  = ~spi_oen_i[3];

      // Always driven outputs
      periph_out_o[PAD_CSN0]    = spi_csn_i;
      periph_oe_o[PAD_CSN0]     = 1'b1;
      periph_out_o[PAD_SCK]     = spi_clk_i;
      periph_oe_o[PAD_SCK]      = 1'b1;
      periph_out_o[PAD_UART_TX] = uart_tx_i;
      periph_oe_o[PAD_UART_TX]  = 1'b1;

      // rx pad is input only, out and enable stay 0

      periph_out_o[PAD_I2C0_SDA] = i2c_sda_out_i[I2C0];
      periph_oe_o[PAD_I2C0_SDA]  = i2c_sda_oe_i[I2C0];
      periph_out_o[PAD_I2C0_SCL] = i2c_scl_out_i[I2C0];
      periph_oe_o[PAD_I2C0_SCL]  = i2c_scl_oe_i[I2C0];
   end

   ////////////////////////////////////////////////////////////
   // Alternate mode
   ////////////////////////////////////////////////////////////

   always_comb begin
      alt_out_o = '0;
      alt_oe_o  = '0;

      // I2C1 has two possible pad pairs
      alt_out_o[PAD_SDIO2]   = i2c_sda_out_i[I2C1];
      alt_oe_o[PAD_SDIO2]    = i2c_sda_oe_i[I2C1];
      alt_out_o[PAD_SDIO3]   = i2c_scl_out_i[I2C1];
      alt_oe_o[PAD_SDIO3]    = i2c_scl_oe_i[I2C1];
      alt_out_o[PAD_UART_RX] = i2c_sda_out_i[I2C1];
      alt_oe_o[PAD_UART_RX]  = i2c_sda_oe_i[I2C1];
      alt_out_o[PAD_UART_TX] = i2c_scl_out_i[I2C1];
      alt_oe_o[PAD_UART_TX]  = i2c_scl_oe_i[I2C1];
   end

endmodule

`default_nettype wire

/* verilog/pad_drive_mux.sv */
// Pure combinational output mux, unused mode parks the pad with out and enable at 0
`timescale 1ns/1ps
`default_nettype none

module pad_drive_mux
   import pad_map_pkg::*;
(
   input  pad_mode_t [N_PADS-1:0] pad_mux_i,
   input  logic      [N_PADS-1:0] periph_out_i,
   input  logic      [N_PADS-1:0] periph_oe_i,
   input  logic      [N_PADS-1:0] alt_out_i,
   input  logic      [N_PADS-1:0] alt_oe_i,
   input  logic      [N_PADS-1:0] gpio_out_i,
   input  logic      [N_PADS-1:0] gpio_dir_i,
   input  pad_cfg_t  [N_PADS-1:0] pad_cfg_i,
   input  pad_cfg_t  [N_PADS-1:0] gpio_cfg_i,
   output logic      [N_PADS-1:0] pad_out_o,
   output logic      [N_PADS-1:0] pad_oe_o,
   output pad_cfg_t  [N_PADS-1:0] pad_cfg_o
);

   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         // Default config everywhere except GPIO pads
         pad_cfg_o[p] = pad_cfg_i[p];

         case (pad_mux_i[p])
            PAD_MODE_PERIPH: begin
               pad_out_o[p] = periph_out_i[p];
               pad_oe_o[p]  = periph_oe_i[p];
            end
            PAD_MODE_GPIO: begin
               pad_out_o[p] = gpio_out_i[p];
               pad_oe_o[p]  = gpio_dir_i[p];
               pad_cfg_o[p] = gpio_cfg_i[p];
            end
            PAD_MODE_ALT: begin
               pad_out_o[p] = alt_out_i[p];
               pad_oe_o[p]  = alt_oe_i[p];
            end
            default: begin
               pad_out_o[p] = 1'b0;
               pad_oe_o[p]  = 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog/pad_sample_router.sv */
// Pure combinational input routing, UART and I2C inputs idle high, GPIO and SPI idle low
`timescale 1ns/1ps
`default_nettype none

module pad_sample_router
   import pad_map_pkg::*;
   import periph_pkg::*;
(
   input  pad_mode_t [N_PADS-1:0]    pad_mux_i,
   input  logic      [N_PADS-1:0]    pad_in_i,
   output logic      [N_PADS-1:0]    gpio_in_o,
   output logic      [SPI_LINES-1:0] spi_sdi_o,
   output logic                      uart_rx_o,
   output logic      [N_I2C-1:0]     i2c_sda_in_o,
   output logic      [N_I2C-1:0]     i2c_scl_in_o
);

   ////////////////////////////////////////////////////////////
   // GPIO and SPI data
   ////////////////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         gpio_in_o[p] = (pad_mux_i[p] == PAD_MODE_GPIO) ? pad_in_i[p] : 1'b0;
      end
   end

   // SPI lines sit on consecutive pads
   always_comb begin
      for (int k = 0; k < SPI_LINES; k++) begin
         spi_sdi_o[k] = (pad_mux_i[PAD_SDIO0+k] == PAD_MODE_PERIPH) ?
                        pad_in_i[PAD_SDIO0+k] : 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // UART and I2C
   ////////////////////////////////////////////////////////////

   assign uart_rx_o = (pad_mux_i[PAD_UART_RX] == PAD_MODE_PERIPH) ?
                      pad_in_i[PAD_UART_RX] : 1'b1;

   assign i2c_sda_in_o[I2C0] = (pad_mux_i[PAD_I2C0_SDA] == PAD_MODE_PERIPH) ?
                               pad_in_i[PAD_I2C0_SDA] : 1'b1;
   assign i2c_scl_in_o[I2C0] = (pad_mux_i[PAD_I2C0_SCL] == PAD_MODE_PERIPH) ?
                               pad_in_i[PAD_I2C0_SCL] : 1'b1;

   // Lower pad wins when both are in alternate mode
   assign i2c_sda_in_o[I2C1] =
      (pad_mux_i[PAD_SDIO2] == PAD_MODE_ALT)   ? pad_in_i[PAD_SDIO2]   :
      (pad_mux_i[PAD_UART_RX] == PAD_MODE_ALT) ? pad_in_i[PAD_UART_RX] :
                                                 1'b1;
   assign i2c_scl_in_o[I2C1] =
      (pad_mux_i[PAD_SDIO3] == PAD_MODE_ALT)   ? pad_in_i[PAD_SDIO3]   :
      (pad_mux_i[PAD_UART_TX] == PAD_MODE_ALT) ? pad_in_i[PAD_UART_TX] :
                                                 1'b1;

endmodule

`default_nettype wire

/* verilog/pad_control.sv */
// Combinational pad control top, no clock or reset port, every output follows its inputs
`timescale 1ns/1ps
`default_nettype none

module pad_control
   import pad_map_pkg::*;
   import periph_pkg::*;
(
   // Configuration
   input  pad_mode_t [N_PADS-1:0]    pad_mux_i,
   input  pad_cfg_t  [N_PADS-1:0]    pad_cfg_i,
   input  pad_cfg_t  [N_PADS-1:0]    gpio_cfg_i,
   output pad_cfg_t  [N_PADS-1:0]    pad_cfg_o,
   // GPIO
   input  logic      [N_PADS-1:0]    gpio_out_i,
   input  logic      [N_PADS-1:0]    gpio_dir_i,
   output logic      [N_PADS-1:0]    gpio_in_o,
   // SPI master
   input  logic                      spi_clk_i,
   input  logic                      spi_csn_i,
   input  logic      [SPI_LINES-1:0] spi_oen_i,
   input  logic      [SPI_LINES-1:0] spi_sdo_i,
   output logic      [SPI_LINES-1:0] spi_sdi_o,
   // UART
   input  logic                      uart_tx_i,
   output logic                      uart_rx_o,
   // I2C
   input  logic      [N_I2C-1:0]     i2c_sda_out_i,
   input  logic      [N_I2C-1:0]     i2c_sda_oe_i,
   output logic      [N_I2C-1:0]     i2c_sda_in_o,
   input  logic      [N_I2C-1:0]     i2c_scl_out_i,
   input  logic      [N_I2C-1:0]     i2c_scl_oe_i,
   output logic      [N_I2C-1:0]     i2c_scl_in_o,
   // Pad frame
   input  logic      [N_PADS-1:0]    pad_in_i,
   output logic      [N_PADS-1:0]    pad_out_o,
   output logic      [N_PADS-1:0]    pad_oe_o
);

   logic [N_PADS-1:0] periph_out;
   logic [N_PADS-1:0] periph_oe;
   logic [N_PADS-1:0] alt_out;
   logic [N_PADS-1:0] alt_oe;

   pad_route_table u_route_table (
      .spi_clk_i     (spi_clk_i),
      .spi_csn_i     (spi_csn_i),
      .spi_oen_i     (spi_oen_i),
      .spi_sdo_i     (spi_sdo_i),
      .uart_tx_i     (uart_tx_i),
      .i2c_sda_out_i (i2c_sda_out_i),
      .i2c_sda_oe_i  (i2c_sda_oe_i),
      .i2c_scl_out_i (i2c_scl_out_i),
      .i2c_scl_oe_i  (i2c_scl_oe_i),
      .periph_out_o  (periph_out),
      .periph_oe_o   (periph_oe),
      .alt_out_o     (alt_out),
      .alt_oe_o      (alt_oe)
   );

   pad_drive_mux u_drive_mux (
      .pad_mux_i    (pad_mux_i),
      .periph_out_i (periph_out),
      .periph_oe_i  (periph_oe),
      .alt_out_i    (alt_out),
      .alt_oe_i     (alt_oe),
      .gpio_out_i   (gpio_out_i),
      .gpio_dir_i   (gpio_dir_i),
      .pad_cfg_i    (pad_cfg_i),
      .gpio_cfg_i   (gpio_cfg_i),
      .pad_out_o    (pad_out_o),
      .pad_oe_o     (pad_oe_o),
      .pad_cfg_o    (pad_cfg_o)
   );

   pad_sample_router u_sample_router (
      .pad_mux_i    (pad_mux_i),
      .pad_in_i     (pad_in_i),
      .gpio_in_o    (gpio_in_o),
      .spi_sdi_o    (spi_sdi_o),
      .uart_rx_o    (uart_rx_o),
      .i2c_sda_in_o (i2c_sda_in_o),
      .i2c_scl_in_o (i2c_scl_in_o)
   );

endmodule

`default_nettype wire

/* tests/pad_control_tb.sv */
// Run from the project root so the case file resolves, and N_CASES must match its data lines
`timescale 1ns/1ps
`default_nettype none

module pad_control_tb
   import pad_map_pkg::*;
   import periph_pkg::*;
();

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 16;
   localparam int N_CASES      = 22;
   localparam int N_WORDS      = 20;
   localparam int LAST_WORD    = N_CASES * N_WORDS - 1;
   localparam int SEED         = 87719;
   localparam int WATCHDOG_NS  = 2 * (RESET_CYCLES + N_CASES + 10) * CLK_PERIOD;

   logic clk_i;
   logic rst_n_i;

   pad_mode_t [N_PADS-1:0]    pad_mux;
   pad_cfg_t  [N_PADS-1:0]    pad_cfg;
   pad_cfg_t  [N_PADS-1:0]    gpio_cfg;
   pad_cfg_t  [N_PADS-1:0]    pad_cfg_out;
   logic      [N_PADS-1:0]    gpio_out;
   logic      [N_PADS-1:0]    gpio_dir;
   logic      [N_PADS-1:0]    gpio_in;
   logic                      spi_clk;
   logic                      spi_csn;
   logic      [SPI_LINES-1:0] spi_oen;
   logic      [SPI_LINES-1:0] spi_sdo;
   logic      [SPI_LINES-1:0] spi_sdi;
   logic                      uart_tx;
   logic                      uart_rx;
   logic      [N_I2C-1:0]     sda_out;
   logic      [N_I2C-1:0]     sda_oe;
   logic      [N_I2C-1:0]     sda_in;
   logic      [N_I2C-1:0]     scl_out;
   logic      [N_I2C-1:0]     scl_oe;
   logic      [N_I2C-1:0]     scl_in;
   logic      [N_PADS-1:0]    pad_in;
   logic      [N_PADS-1:0]    pad_out;
   logic      [N_PADS-1:0]    pad_oe;

   // One row per case, 13 stimulus words then 7 expected words
   logic [19:0] case_mem [0:LAST_WORD];
   int          cur_case;

   pad_control u_dut (
      .pad_mux_i     (pad_mux),
      .pad_cfg_i     (pad_cfg),
      .gpio_cfg_i    (gpio_cfg),
      .pad_cfg_o     (pad_cfg_out),
      .gpio_out_i    (gpio_out),
      .gpio_dir_i    (gpio_dir),
      .gpio_in_o     (gpio_in),
      .spi_clk_i     (spi_clk),
      .spi_csn_i     (spi_csn),
      .spi_oen_i     (spi_oen),
      .spi_sdo_i     (spi_sdo),
      .spi_sdi_o     (spi_sdi),
      .uart_tx_i     (uart_tx),
      .uart_rx_o     (uart_rx),
      .i2c_sda_out_i (sda_out),
      .i2c_sda_oe_i  (sda_oe),
      .i2c_sda_in_o  (sda_in),
      .i2c_scl_out_i (scl_out),
      .i2c_scl_oe_i  (scl_oe),
      .i2c_scl_in_o  (scl_in),
      .pad_in_i      (pad_in),
      .pad_out_o     (pad_out),
      .pad_oe_o      (pad_oe)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("CHECK FAILED case %0d %s: got 0x%0h, expected 0x%0h",
                  cur_case, name, actual, expected);
         abort_run();
      end
   endtask

   function automatic logic [31:0] case_word(input int idx);
      return 32'(case_mem[idx]);
   endfunction

   // GPIO pads take the GPIO config, all others the default
   function automatic pad_cfg_t expected_cfg(input int p);
      if (pad_mux[p] == PAD_MODE_GPIO)
         return gpio_cfg[p];
      return pad_cfg[p];
   endfunction

   task automatic apply_case(input int c);
      int base;
      base = c * N_WORDS;
      for (int p = 0; p < N_PADS; p++) begin
         pad_mux[p]  = pad_mode_t'(case_mem[base][2*p +: 2]);
         pad_cfg[p]  = pad_cfg_t'($urandom);
         gpio_cfg[p] = pad_cfg_t'($urandom);
      end
      gpio_out = case_mem[base+1][N_PADS-1:0];
      gpio_dir = case_mem[base+2][N_PADS-1:0];
      spi_sdo  = case_mem[base+3][SPI_LINES-1:0];
      spi_oen  = case_mem[base+4][SPI_LINES-1:0];
      spi_csn  = case_mem[base+5][0];
      spi_clk  = case_mem[base+6][0];
      uart_tx  = case_mem[base+7][0];
      sda_out  = case_mem[base+8][N_I2C-1:0];
      sda_oe   = case_mem[base+9][N_I2C-1:0];
      scl_out  = case_mem[base+10][N_I2C-1:0];
      scl_oe   = case_mem[base+11][N_I2C-1:0];
      pad_in   = case_mem[base+12][N_PADS-1:0];
   endtask

   task automatic check_case(input int c);
      int base;
      base = c * N_WORDS + 13;
      check_value("pad_out_o", 32'(pad_out), case_word(base));
      check_value("pad_oe_o", 32'(pad_oe), case_word(base + 1));
      check_value("gpio_in_o", 32'(gpio_in), case_word(base + 2));
      check_value("spi_sdi_o", 32'(spi_sdi), case_word(base + 3));
      check_value("uart_rx_o", 32'(uart_rx), case_word(base + 4));
      check_value("i2c_sda_in_o", 32'(sda_in), case_word(base + 5));
      check_value("i2c_scl_in_o", 32'(scl_in), case_word(base + 6));
      for (int p = 0; p < N_PADS; p++) begin
         check_value($sformatf("pad_cfg_o[%0d]", p), 32'(pad_cfg_out[p]),
                     32'(expected_cfg(p)));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      clk_i    = 1'b0;
      rst_n_i  = 1'b0;
      cur_case = 0;
      for (int p = 0; p < N_PADS; p++) begin
         pad_mux[p]  = PAD_MODE_NONE;
         pad_cfg[p]  = '0;
         gpio_cfg[p] = '0;
      end
      gpio_out = '0;
      gpio_dir = '0;
      spi_clk  = 1'b0;
      spi_csn  = 1'b1;
      spi_oen  = '1;
      spi_sdo  = '0;
      uart_tx  = 1'b1;
      sda_out  = '0;
      sda_oe   = '0;
      scl_out  = '0;
      scl_oe   = '0;
      pad_in   = '0;
      void'($urandom(SEED));

      // Marker word, overwritten only by a complete file
      case_mem[LAST_WORD] = '1;
      $readmemh("tests/pad_control_cases.txt", case_mem);
      if (case_mem[LAST_WORD] > 20'd3) begin
         $display("Case file is missing or holds fewer than %0d cases", N_CASES);
         abort_run();
      end

      repeat (RESET_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;

      for (int c = 0; c < N_CASES; c++) begin
         @(negedge clk_i);
         cur_case = c;
         apply_case(c);
         @(posedge clk_i);
         check_case(c);
      end

      $display("Testbench passed");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
      abort_run();
   end

endmodule

`default_nettype wire

/* tests/pad_control_cases.txt */
// mux gpo gpd sdo oen csn clk tx sdao sdae sclo scle pin
//   then expected: pout poe gpi sdi rx sdai scli
// All pads in peripheral mode
00000 3FF 3FF A 0 1 0 1 1 1 0 1 155 19A 3BF 000 5 1 3 2
00000 000 000 5 F 0 1 0 2 0 1 2 2AA 225 0B0 000 A 0 2 3
00000 000 000 F 6 1 1 1 3 3 3 3 000 3BF 3B9 000 0 0 2 2
00000 155 155 0 3 0 0 0 0 2 0 1 040 000 2BC 000 0 1 2 2
// All pads in GPIO mode
55555 2C3 1F0 F 0 1 1 1 3 3 3 3 36C 2C3 1F0 36C 0 1 3 3
55555 13A 2C5 0 F 0 0 0 0 0 0 0 0C9 13A 2C5 0C9 0 1 3 3
55555 3FF 000 A 5 1 0 1 1 2 2 1 3FF 3FF 000 3FF 0 1 3 3
// Alternate mode and I2C1 pad priority
AAAAA 3FF 3FF F 0 1 1 1 2 2 0 2 044 044 0CC 000 0 1 3 1
AAAAA 000 000 0 F 0 0 0 1 0 2 2 088 088 088 000 0 1 1 3
AAAAA 000 000 0 0 0 0 0 3 3 3 3 0C0 0CC 0CC 000 0 1 1 1
0A000 000 000 3 0 1 0 1 2 3 1 2 0C3 253 1FF 000 3 1 2 2
000A0 000 000 F 0 0 1 0 2 2 2 0 1F4 02F 0B7 000 0 1 3 0
AFAFA 3FF 3FF F 0 1 1 1 3 3 3 3 3FF 000 000 000 0 1 3 3
F6F6F 080 088 0 0 1 1 1 0 2 3 3 00C 080 0CC 008 0 1 3 3
// Unused mode
FFFFF 3FF 3FF F 0 1 1 1 3 3 3 3 3FF 000 000 000 0 1 3 3
FFFFF 155 2AA 5 A 0 1 0 1 2 2 1 000 000 000 000 0 1 3 3
// Mixed modes per pad
4E4E4 2AA 3FF 5 2 1 0 1 3 2 1 3 2D6 377 277 202 0 1 2 3
B1B1B 155 0F0 8 0 0 1 0 0 0 0 0 3CF 04C 0C8 044 8 1 3 3
0A090 004 004 3 C 0 1 1 2 2 2 2 1C1 0EF 0FF 000 1 1 3 0
9D2E7 3A5 1E3 9 7 1 1 0 2 0 1 1 27B 124 162 042 0 1 1 3
16C58 0D8 3C4 E 1 0 0 1 3 3 2 1 159 0C8 3D4 108 1 1 3 2
27390 084 004 6 8 1 1 0 1 2 2 3 38E 0AE 22F 084 2 1 3 3

/* filelist.f */
verilog/pad_map_pkg.sv
verilog/periph_pkg.sv
verilog/pad_route_table.sv
verilog/pad_drive_mux.sv
verilog/pad_sample_router.sv
verilog/pad_control.sv
tests/pad_control_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the pad_control testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -f filelist.f --top-module pad_control_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
   echo "ERROR: Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vpad_control_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Testbench failed" "$LOG_FILE"; then
   echo "RESULT: simulation reported failure"
   exit 1
fi

if [ $sim_status -ne 0 ]; then
   echo "ERROR: simulator exited with status $sim_status"
   exit 1
fi

echo "RESULT: simulation passed"
exit 0
